// ==== hw/exec_pkg.sv ====
package exec_pkg;

    ////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////

    localparam int XLEN       = 32;
    localparam int CSR_ADDR_W = 12;
    localparam int TAG_W      = 3;

    ////////////////////////////////////////////////////////////
    // Enumerations
    ////////////////////////////////////////////////////////////

    // Decoded operation from the decode stage
    typedef enum logic [5:0] {
        NOP,
        LUI,
        ADD, SUB, SLT, SLTU,
        XOR, OR, AND,
        SLL, SRL, SRA,
        JAL, JALR,
        BEQ, BNE, BLT, BLTU, BGE, BGEU,
        LB, LBU, LH, LHU, LW,
        SB, SH, SW,
        CSRRW, CSRRS, CSRRC,
        CSRRWI, CSRRSI, CSRRCI,
        ECALL, EBREAK, MRET
    } op_e;

    typedef enum logic [1:0] {
        CSR_NONE,
        CSR_WRITE,
        CSR_SET,
        CSR_CLEAR
    } csr_op_e;

    // Encoded as in the mstatus MPP field
    typedef enum logic [1:0] {
        PRIV_USER    = 2'd0,
        PRIV_SUPER   = 2'd1,
        PRIV_MACHINE = 2'd3
    } priv_e;

    // Standard mcause codes with EXC_NONE on a reserved value
    typedef enum logic [3:0] {
        INSTR_MISALIGNED   = 4'd0,
        INSTR_ACCESS_FAULT = 4'd1,
        ILLEGAL_INSTR      = 4'd2,
        BREAKPOINT         = 4'd3,
        LOAD_ACCESS_FAULT  = 4'd5,
        ECALL_U            = 4'd8,
        EXC_NONE           = 4'd10,
        ECALL_M            = 4'd11
    } exc_code_e;

    ////////////////////////////////////////////////////////////
    // Grouped signals
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic equal;
        logic less_than;
        logic less_than_unsigned;
    } cmp_flags_t;

    // Faults detected upstream in fetch and decode
    typedef struct packed {
        logic illegal_instr;
        logic misaligned_fetch;
        logic instr_access_fault;
        logic load_access_fault;
    } fault_in_t;

    typedef struct packed {
        logic [XLEN-1:0] address;
        logic            read_enable;
        logic [3:0]      write_enable;
        logic [XLEN-1:0] write_data;
    } mem_req_t;

    typedef struct packed {
        logic [CSR_ADDR_W-1:0] address;
        logic                  read_enable;
        logic                  write_enable;
        csr_op_e               operation;
        logic [XLEN-1:0]       write_data;
    } csr_req_t;

    typedef struct packed {
        logic      raise_exception;
        logic      machine_return;
        logic      interrupt_ack;
        exc_code_e exception_code;
    } trap_t;

endpackage

// ==== hw/alu.sv ====
module alu
    import exec_pkg::*;
(
    input  op_e             op_i,
    input  logic [XLEN-1:0] pc_i,
    input  logic [XLEN-1:0] op_a_i,
    input  logic [XLEN-1:0] op_b_i,
    input  logic [XLEN-1:0] op_c_i,
    input  logic            compressed_i,
    output logic [XLEN-1:0] sum_o,
    output logic [XLEN-1:0] link_sum_o,
    output logic [XLEN-1:0] result_o,
    output cmp_flags_t      flags_o
);

    logic signed [XLEN-1:0] a_signed;
    logic signed [XLEN-1:0] b_signed;
    logic [4:0]             shamt;
    logic [XLEN-1:0]        add2_a;
    logic [XLEN-1:0]        add2_b;

    assign a_signed = op_a_i;
    assign b_signed = op_b_i;
    assign shamt    = op_b_i[4:0];

    ////////////////////////////////////////////////////////////
    // Adders
    ////////////////////////////////////////////////////////////

    assign sum_o = op_a_i + op_b_i;

    // Second adder serves link address, SUB and branch target
    always_comb begin
        add2_a = pc_i;
        add2_b = op_c_i;
        unique case (op_i)
            JAL, JALR: add2_b = compressed_i ? XLEN'(2) : XLEN'(4);
            SUB: begin
                add2_a = op_a_i;
                add2_b = -op_b_i;
            end
            default: ;
        endcase
    end

    assign link_sum_o = add2_a + add2_b;

    ////////////////////////////////////////////////////////////
    // Compare and result select
    ////////////////////////////////////////////////////////////

    assign flags_o.equal              = (op_a_i == op_b_i);
    assign flags_o.less_than          = (a_signed < b_signed);
    assign flags_o.less_than_unsigned = (op_a_i < op_b_i);

    always_comb begin
        unique case (op_i)
            SLT:     result_o = {{(XLEN-1){1'b0}}, flags_o.less_than};
            SLTU:    result_o = {{(XLEN-1){1'b0}}, flags_o.less_than_unsigned};
            XOR:     result_o = op_a_i ^ op_b_i;
            OR:      result_o = op_a_i | op_b_i;
            AND:     result_o = op_a_i & op_b_i;
            SLL:     result_o = op_a_i << shamt;
            SRL:     result_o = op_a_i >> shamt;
            SRA:     result_o = $unsigned(a_signed >>> shamt);
            // Immediate already shifted by decode
            LUI:     result_o = op_b_i;
            default: result_o = sum_o;
        endcase
    end

endmodule

// ==== hw/lsu_request.sv ====
module lsu_request
    import exec_pkg::*;
(
    input  op_e             op_i,
    input  logic [XLEN-1:0] sum_i,
    input  logic [XLEN-1:0] store_data_i,
    output mem_req_t        mem_o
);

    logic [1:0] lane;

    assign lane = sum_i[1:0];

    // Bus is word addressed, lanes select the bytes
    assign mem_o.address     = {sum_i[XLEN-1:2], 2'b00};
    assign mem_o.read_enable = op_i inside {LB, LBU, LH, LHU, LW};

    ////////////////////////////////////////////////////////////
    // Byte enables
    ////////////////////////////////////////////////////////////

    always_comb begin
        unique case (op_i)
            SB: begin
                unique case (lane)
                    2'b11:   mem_o.write_enable = 4'b1000;
                    2'b10:   mem_o.write_enable = 4'b0100;
                    2'b01:   mem_o.write_enable = 4'b0010;
                    default: mem_o.write_enable = 4'b0001;
                endcase
            end
            SH:      mem_o.write_enable = lane[1] ? 4'b1100 : 4'b0011;
            SW:      mem_o.write_enable = 4'b1111;
            default: mem_o.write_enable = 4'b0000;
        endcase
    end

    // Replicate so every enabled lane sees the value
    always_comb begin
        unique case (op_i)
            SB:      mem_o.write_data = {4{store_data_i[7:0]}};
            SH:      mem_o.write_data = {2{store_data_i[15:0]}};
            default: mem_o.write_data = store_data_i;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    always_comb begin
        assert (mem_o.write_enable inside {4'b0000, 4'b0001, 4'b0010, 4'b0100, 4'b1000,
                                           4'b0011, 4'b1100, 4'b1111}
                && !(mem_o.read_enable && (|mem_o.write_enable)))
            else $error("lsu_request: bad byte enables %b", mem_o.write_enable);
    end

endmodule

// ==== hw/csr_access.sv ====
module csr_access
    import exec_pkg::*;
(
    input  op_e             op_i,
    input  logic [XLEN-1:0] instruction_i,
    input  logic [XLEN-1:0] op_a_i,
    input  priv_e           privilege_i,
    output csr_req_t        csr_o,
    output logic            illegal_o
);

    logic [CSR_ADDR_W-1:0] addr;
    logic [4:0]            rd;
    logic [4:0]            rs1;
    logic                  read_req;
    logic                  write_req;

    assign addr = instruction_i[31:20];
    assign rd   = instruction_i[11:7];
    assign rs1  = instruction_i[19:15];

    ////////////////////////////////////////////////////////////
    // Access decode
    ////////////////////////////////////////////////////////////

    // rd of zero skips the read, rs1 of zero skips the write
    always_comb begin
        read_req  = 1'b0;
        write_req = 1'b0;
        csr_o.operation = CSR_NONE;
        unique case (op_i)
            CSRRW, CSRRWI: begin
                read_req  = (rd != '0);
                write_req = 1'b1;
                csr_o.operation = CSR_WRITE;
            end
            CSRRS, CSRRSI: begin
                read_req  = 1'b1;
                write_req = (rs1 != '0);
                csr_o.operation = CSR_SET;
            end
            CSRRC, CSRRCI: begin
                read_req  = 1'b1;
                write_req = (rs1 != '0);
                csr_o.operation = CSR_CLEAR;
            end
            default: ;
        endcase
    end

    // Immediate forms carry the zero-extended rs1 field
    assign csr_o.write_data = (op_i inside {CSRRW, CSRRS, CSRRC})
                            ? op_a_i
                            : {{(XLEN-5){1'b0}}, rs1};

    // Top two address bits set means read-only, next two the minimum privilege
    assign illegal_o = (write_req && addr[11:10] == 2'b11)
                     || ((read_req || write_req) && addr[9:8] > privilege_i);

    assign csr_o.address      = addr;
    assign csr_o.read_enable  = read_req && !illegal_o;
    assign csr_o.write_enable = write_req && !illegal_o;

    always_comb begin
        assert (!(csr_o.write_enable && illegal_o))
            else $error("csr_access: write enabled on illegal access to %h", addr);
    end

endmodule

// ==== hw/flow_control.sv ====
module flow_control
    import exec_pkg::*;
(
    input  logic             clk,
    input  logic             reset_n,
    input  logic             sys_reset_i,
    input  op_e              op_i,
    input  logic [TAG_W-1:0] tag_i,
    input  priv_e            privilege_i,
    input  fault_in_t        faults_i,
    input  logic             csr_illegal_i,
    input  mem_req_t         mem_i,
    input  logic [XLEN-1:0]  sum_i,
    input  logic [XLEN-1:0]  link_sum_i,
    input  cmp_flags_t       flags_i,
    input  logic             interrupt_pending_i,
    output logic             jump_o,
    output logic [XLEN-1:0]  jump_target_o,
    output logic             killed_o,
    output trap_t            trap_o
);

    logic [TAG_W-1:0] tag_q;
    logic             taken;
    logic             mem_access;
    logic             flow_change;

    function automatic trap_t exception(exc_code_e code);
        trap_t t;
        t = '0;
        t.raise_exception = 1'b1;
        t.exception_code  = code;
        return t;
    endfunction

    ////////////////////////////////////////////////////////////
    // Kill
    ////////////////////////////////////////////////////////////

    // Stale flow carries the previous tag
    assign killed_o = (tag_q != tag_i) || sys_reset_i;

    ////////////////////////////////////////////////////////////
    // Branch and jump
    ////////////////////////////////////////////////////////////

    always_comb begin
        unique case (op_i)
            BEQ:       taken = flags_i.equal;
            BNE:       taken = !flags_i.equal;
            BLT:       taken = flags_i.less_than;
            BLTU:      taken = flags_i.less_than_unsigned;
            BGE:       taken = !flags_i.less_than;
            BGEU:      taken = !flags_i.less_than_unsigned;
            JAL, JALR: taken = 1'b1;
            default:   taken = 1'b0;
        endcase
    end

    assign jump_o = taken && !killed_o;

    always_comb begin
        unique case (op_i)
            JALR:    jump_target_o = {sum_i[XLEN-1:1], 1'b0};
            JAL:     jump_target_o = sum_i;
            default: jump_target_o = link_sum_i;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Traps from highest priority down
    ////////////////////////////////////////////////////////////

    assign mem_access = mem_i.read_enable || (|mem_i.write_enable);

    always_comb begin
        trap_o = '0;
        trap_o.exception_code = EXC_NONE;
        if (killed_o) begin
            trap_o.exception_code = EXC_NONE;
        end else if (faults_i.instr_access_fault) begin
            trap_o = exception(INSTR_ACCESS_FAULT);
        end else if (faults_i.illegal_instr || csr_illegal_i) begin
            trap_o = exception(ILLEGAL_INSTR);
        end else if (faults_i.misaligned_fetch) begin
            trap_o = exception(INSTR_MISALIGNED);
        end else if (op_i == ECALL) begin
            trap_o = exception((privilege_i == PRIV_USER) ? ECALL_U : ECALL_M);
        end else if (op_i == EBREAK) begin
            trap_o = exception(BREAKPOINT);
        end else if (faults_i.load_access_fault && mem_access) begin
            trap_o = exception(LOAD_ACCESS_FAULT);
        end else if (op_i == MRET) begin
            trap_o.machine_return = 1'b1;
        end else if (interrupt_pending_i && op_i != NOP) begin
            trap_o.interrupt_ack = 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Tag register
    ////////////////////////////////////////////////////////////

    // Advances regardless of stall
    assign flow_change = jump_o || trap_o.raise_exception
                       || trap_o.machine_return || trap_o.interrupt_ack;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            tag_q <= '0;
        end else if (flow_change) begin
            tag_q <= tag_q + 1'b1;
        end
    end

    a_trap_onehot: assert property (@(posedge clk) disable iff (!reset_n)
        $onehot0({trap_o.raise_exception, trap_o.machine_return, trap_o.interrupt_ack}))
        else $error("flow_control: more than one trap kind active");

endmodule

// ==== hw/execute_stage.sv ====
module execute_stage
    import exec_pkg::*;
(
    input  logic             clk,
    input  logic             reset_n,
    input  logic             sys_reset_i,
    input  logic             stall_i,
    input  logic [XLEN-1:0]  instruction_i,
    input  logic [XLEN-1:0]  pc_i,
    input  logic [XLEN-1:0]  op_a_i,
    input  logic [XLEN-1:0]  op_b_i,
    input  logic [XLEN-1:0]  op_c_i,
    input  op_e              op_i,
    input  logic             compressed_i,
    input  logic [TAG_W-1:0] tag_i,
    input  priv_e            privilege_i,
    input  fault_in_t        faults_i,
    input  logic [XLEN-1:0]  csr_read_data_i,
    input  logic             interrupt_pending_i,
    output mem_req_t         mem_o,
    output csr_req_t         csr_o,
    output logic             jump_o,
    output logic [XLEN-1:0]  jump_target_o,
    output trap_t            trap_o,
    output logic             killed_o,
    output logic [XLEN-1:0]  result_o,
    output logic             write_enable_o,
    output op_e              op_o
);

    logic [XLEN-1:0] sum;
    logic [XLEN-1:0] link_sum;
    logic [XLEN-1:0] alu_result;
    cmp_flags_t      flags;
    logic            csr_illegal;
    logic [XLEN-1:0] result;
    logic            write_enable;

    alu u_alu (
        .op_i         (op_i),
        .pc_i         (pc_i),
        .op_a_i       (op_a_i),
        .op_b_i       (op_b_i),
        .op_c_i       (op_c_i),
        .compressed_i (compressed_i),
        .sum_o        (sum),
        .link_sum_o   (link_sum),
        .result_o     (alu_result),
        .flags_o      (flags)
    );

    // Store data arrives on the third operand
    lsu_request u_lsu_request (
        .op_i         (op_i),
        .sum_i        (sum),
        .store_data_i (op_c_i),
        .mem_o        (mem_o)
    );

    csr_access u_csr_access (
        .op_i          (op_i),
        .instruction_i (instruction_i),
        .op_a_i        (op_a_i),
        .privilege_i   (privilege_i),
        .csr_o         (csr_o),
        .illegal_o     (csr_illegal)
    );

    flow_control u_flow_control (
        .clk                 (clk),
        .reset_n             (reset_n),
        .sys_reset_i         (sys_reset_i),
        .op_i                (op_i),
        .tag_i               (tag_i),
        .privilege_i         (privilege_i),
        .faults_i            (faults_i),
        .csr_illegal_i       (csr_illegal),
        .mem_i               (mem_o),
        .sum_i               (sum),
        .link_sum_i          (link_sum),
        .flags_i             (flags),
        .interrupt_pending_i (interrupt_pending_i),
        .jump_o              (jump_o),
        .jump_target_o       (jump_target_o),
        .killed_o            (killed_o),
        .trap_o              (trap_o)
    );

    ////////////////////////////////////////////////////////////
    // Result and write enable
    ////////////////////////////////////////////////////////////

    always_comb begin
        unique case (op_i)
            CSRRW, CSRRS, CSRRC,
            CSRRWI, CSRRSI, CSRRCI: result = csr_read_data_i;
            JAL, JALR, SUB:         result = link_sum;
            default:                result = alu_result;
        endcase
    end

    always_comb begin
        unique case (op_i)
            NOP, SB, SH, SW,
            BEQ, BNE, BLT, BLTU, BGE, BGEU: write_enable = 1'b0;
            default: write_enable = !(killed_o || trap_o.raise_exception);
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Output registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            write_enable_o <= 1'b0;
            op_o           <= NOP;
            result_o       <= '0;
        end else if (!stall_i) begin
            write_enable_o <= write_enable;
            op_o           <= op_i;
            result_o       <= result;
        end
    end

endmodule

// ==== tb/exec_model.svh ====
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

// One cycle of execute stage inputs
typedef struct packed {
    logic [XLEN-1:0]  instruction;
    logic [XLEN-1:0]  pc;
    logic [XLEN-1:0]  op_a;
    logic [XLEN-1:0]  op_b;
    logic [XLEN-1:0]  op_c;
    op_e              op;
    logic             compressed;
    logic [TAG_W-1:0] tag;
    priv_e            privilege;
    fault_in_t        faults;
    logic             sys_reset;
    logic             stall;
    logic [XLEN-1:0]  csr_rdata;
    logic             irq;
} stim_t;

// Expected combinational outputs plus the values headed for the output registers
typedef struct packed {
    mem_req_t        mem;
    csr_req_t        csr;
    logic            jump;
    logic [XLEN-1:0] target;
    logic            killed;
    trap_t           trap;
    logic [XLEN-1:0] result;
    logic            write_enable;
} expect_t;

function automatic mem_req_t expected_mem(input stim_t s);
    mem_req_t        m;
    logic [XLEN-1:0] addr;
    addr = s.op_a + s.op_b;
    m.address = addr & ~XLEN'(3);
    m.read_enable = s.op inside {LB, LBU, LH, LHU, LW};
    m.write_enable = 4'b0000;
    m.write_data = s.op_c;
    case (s.op)
        SB: begin
            m.write_enable = 4'b0001 << addr[1:0];
            m.write_data = {4{s.op_c[7:0]}};
        end
        SH: begin
            m.write_enable = addr[1] ? 4'b1100 : 4'b0011;
            m.write_data = {2{s.op_c[15:0]}};
        end
        SW: m.write_enable = 4'b1111;
        default: ;
    endcase
    return m;
endfunction

function automatic csr_req_t expected_csr(input stim_t s, output logic illegal);
    csr_req_t c;
    logic     rd_req;
    logic     wr_req;
    c.address = s.instruction[31:20];
    c.operation = CSR_NONE;
    rd_req = 1'b0;
    wr_req = 1'b0;
    if (s.op inside {CSRRW, CSRRS, CSRRC})
        c.write_data = s.op_a;
    else
        c.write_data = XLEN'(s.instruction[19:15]);
    if (s.op inside {CSRRW, CSRRWI}) begin
        c.operation = CSR_WRITE;
        rd_req = s.instruction[11:7] != 5'd0;
        wr_req = 1'b1;
    end else if (s.op inside {CSRRS, CSRRSI, CSRRC, CSRRCI}) begin
        c.operation = (s.op inside {CSRRS, CSRRSI}) ? CSR_SET : CSR_CLEAR;
        rd_req = 1'b1;
        wr_req = s.instruction[19:15] != 5'd0;
    end
    // Read-only space, then minimum privilege from address bits 9:8
    illegal = (wr_req && c.address[11:10] == 2'b11)
            || ((rd_req || wr_req) && c.address[9:8] > 2'(s.privilege));
    c.read_enable = rd_req && !illegal;
    c.write_enable = wr_req && !illegal;
    return c;
endfunction

function automatic trap_t expected_trap(input stim_t s, input logic killed,
                                        input logic csr_illegal, input logic mem_access);
    trap_t t;
    t = '0;
    t.exception_code = EXC_NONE;
    if (killed)
        return t;
    t.raise_exception = 1'b1;
    if (s.faults.instr_access_fault)
        t.exception_code = INSTR_ACCESS_FAULT;
    else if (s.faults.illegal_instr || csr_illegal)
        t.exception_code = ILLEGAL_INSTR;
    else if (s.faults.misaligned_fetch)
        t.exception_code = INSTR_MISALIGNED;
    else if (s.op == ECALL)
        t.exception_code = (s.privilege == PRIV_USER) ? ECALL_U : ECALL_M;
    else if (s.op == EBREAK)
        t.exception_code = BREAKPOINT;
    else if (s.faults.load_access_fault && mem_access)
        t.exception_code = LOAD_ACCESS_FAULT;
    else begin
        t.raise_exception = 1'b0;
        if (s.op == MRET)
            t.machine_return = 1'b1;
        else if (s.irq && s.op != NOP)
            t.interrupt_ack = 1'b1;
    end
    return t;
endfunction

function automatic expect_t predict_outputs(input stim_t s, input logic [TAG_W-1:0] tag);
    expect_t         e;
    logic            csr_illegal;
    logic            taken;
    logic [XLEN-1:0] sum;
    logic [4:0]      sh;
    sum = s.op_a + s.op_b;
    sh = s.op_b[4:0];
    e.mem = expected_mem(s);
    e.csr = expected_csr(s, csr_illegal);
    e.killed = s.sys_reset || (s.tag != tag);
    case (s.op)
        BEQ:       taken = s.op_a == s.op_b;
        BNE:       taken = s.op_a != s.op_b;
        BLT:       taken = $signed(s.op_a) < $signed(s.op_b);
        BLTU:      taken = s.op_a < s.op_b;
        BGE:       taken = $signed(s.op_a) >= $signed(s.op_b);
        BGEU:      taken = s.op_a >= s.op_b;
        JAL, JALR: taken = 1'b1;
        default:   taken = 1'b0;
    endcase
    e.jump = taken && !e.killed;
    case (s.op)
        JAL:     e.target = sum;
        JALR:    e.target = sum & ~XLEN'(1);
        SUB:     e.target = s.op_a - s.op_b;
        default: e.target = s.pc + s.op_c;
    endcase
    e.trap = expected_trap(s, e.killed, csr_illegal,
                           e.mem.read_enable || (|e.mem.write_enable));
    case (s.op)
        LUI:       e.result = s.op_b;
        SUB:       e.result = s.op_a - s.op_b;
        SLT:       e.result = XLEN'($signed(s.op_a) < $signed(s.op_b));
        SLTU:      e.result = XLEN'(s.op_a < s.op_b);
        XOR:       e.result = s.op_a ^ s.op_b;
        OR:        e.result = s.op_a | s.op_b;
        AND:       e.result = s.op_a & s.op_b;
        SLL:       e.result = s.op_a << sh;
        SRL:       e.result = s.op_a >> sh;
        SRA:       e.result = $unsigned($signed(s.op_a) >>> sh);
        JAL, JALR: e.result = s.pc + (s.compressed ? XLEN'(2) : XLEN'(4));
        CSRRW, CSRRS, CSRRC, CSRRWI, CSRRSI, CSRRCI: e.result = s.csr_rdata;
        default:   e.result = sum;
    endcase
    if (s.op inside {NOP, SB, SH, SW, BEQ, BNE, BLT, BLTU, BGE, BGEU})
        e.write_enable = 1'b0;
    else
        e.write_enable = !e.killed && !e.trap.raise_exception;
    return e;
endfunction

`endif

// ==== tb/tb_execute.sv ====
module tb_execute
    import exec_pkg::*;
();

`include "exec_model.svh"

    localparam int NUM_TESTS       = 6;
    localparam int CYCLES_PER_TEST = 300;
    localparam int TIMEOUT_CYCLES  = NUM_TESTS * CYCLES_PER_TEST + 700;

    logic             clk;
    logic             reset_n;
    logic             sys_reset;
    logic             stall;
    logic [XLEN-1:0]  instruction;
    logic [XLEN-1:0]  pc;
    logic [XLEN-1:0]  op_a;
    logic [XLEN-1:0]  op_b;
    logic [XLEN-1:0]  op_c;
    op_e              op;
    logic             compressed;
    logic [TAG_W-1:0] tag;
    priv_e            privilege;
    fault_in_t        faults;
    logic [XLEN-1:0]  csr_read_data;
    logic             interrupt_pending;
    mem_req_t         mem;
    csr_req_t         csr;
    logic             jump;
    logic [XLEN-1:0]  jump_target;
    trap_t            trap;
    logic             killed;
    logic [XLEN-1:0]  result;
    logic             write_enable;
    op_e              op_out;

    // Model state
    logic [31:0]      rng;
    logic [TAG_W-1:0] model_tag;
    logic [XLEN-1:0]  exp_result;
    logic             exp_we;
    op_e              exp_op;
    logic             flow_changed;
    int               stall_left;
    int               errors;
    int               checks;
    int               cycles;

    execute_stage uut (
        .clk                 (clk),
        .reset_n             (reset_n),
        .sys_reset_i         (sys_reset),
        .stall_i             (stall),
        .instruction_i       (instruction),
        .pc_i                (pc),
        .op_a_i              (op_a),
        .op_b_i              (op_b),
        .op_c_i              (op_c),
        .op_i                (op),
        .compressed_i        (compressed),
        .tag_i               (tag),
        .privilege_i         (privilege),
        .faults_i            (faults),
        .csr_read_data_i     (csr_read_data),
        .interrupt_pending_i (interrupt_pending),
        .mem_o               (mem),
        .csr_o               (csr),
        .jump_o              (jump),
        .jump_target_o       (jump_target),
        .trap_o              (trap),
        .killed_o            (killed),
        .result_o            (result),
        .write_enable_o      (write_enable),
        .op_o                (op_out)
    );

    ////////////////////////////////////////////////////////////
    // Random source and stimulus
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function logic [31:0] rand32();
        rng = xorshift32(rng);
        return rng;
    endfunction

    // Each test draws from its own slice of the opcode list
    function automatic op_e pick_op(input int test, input logic [31:0] r);
        case (test)
            1:       return op_e'(32'(LUI) + r % 13);
            2:       return op_e'(32'(BEQ) + r % 6);
            3:       return op_e'(32'(LB) + r % 8);
            4:       return op_e'(32'(CSRRW) + r % 6);
            5:       return r[31] ? op_e'(32'(ECALL) + r % 3) : op_e'(r % 37);
            default: return op_e'(r % 37);
        endcase
    endfunction

    function automatic string test_name(input int test);
        case (test)
            1:       return "alu";
            2:       return "branch";
            3:       return "load_store";
            4:       return "csr";
            5:       return "trap";
            default: return "stall";
        endcase
    endfunction

    task automatic random_stimulus(input int test, output stim_t s);
        logic [31:0] r;
        logic [31:0] f;
        r = rand32();
        s = '0;
        s.instruction = rand32();
        s.pc = rand32() & ~XLEN'(1);
        s.op_a = rand32();
        s.op_b = rand32();
        s.op_c = rand32();
        s.op = pick_op(test, rand32());
        s.compressed = r[0];
        s.csr_rdata = rand32();
        s.tag = model_tag;
        if (test != 1 && r[7:4] == 4'd0)
            s.tag = TAG_W'(rand32());
        case (r[9:8])
            2'd0:    s.privilege = PRIV_USER;
            2'd1:    s.privilege = PRIV_SUPER;
            default: s.privilege = PRIV_MACHINE;
        endcase
        case (test)
            2: begin
                if (r[11:10] == 2'd0)
                    s.op_b = s.op_a;
                // Stale instruction right behind a flow change
                if (flow_changed && r[12]) begin
                    s.op = ADD;
                    s.tag = model_tag - TAG_W'(1);
                end
            end
            4: begin
                if (r[13])
                    s.instruction[11:7] = 5'd0;
                if (r[14])
                    s.instruction[19:15] = 5'd0;
            end
            5: begin
                f = rand32() & rand32();
                s.faults = fault_in_t'(f[3:0]);
                s.irq = r[15];
                s.sys_reset = r[19:16] == 4'd0;
            end
            6: begin
                if (stall_left == 0 && r[17:16] == 2'd0)
                    stall_left = 1 + int'(r[22:20]);
                if (stall_left > 0) begin
                    s.stall = 1'b1;
                    stall_left--;
                end
            end
            default: ;
        endcase
    endtask

    task automatic drive_inputs(input stim_t s);
        instruction <= s.instruction;
        pc <= s.pc;
        op_a <= s.op_a;
        op_b <= s.op_b;
        op_c <= s.op_c;
        op <= s.op;
        compressed <= s.compressed;
        tag <= s.tag;
        privilege <= s.privilege;
        faults <= s.faults;
        sys_reset <= s.sys_reset;
        stall <= s.stall;
        csr_read_data <= s.csr_rdata;
        interrupt_pending <= s.irq;
    endtask

    ////////////////////////////////////////////////////////////
    // Checking
    ////////////////////////////////////////////////////////////

    task automatic report_mismatch(input string name, input logic [127:0] expected,
                                   input logic [127:0] actual);
        errors++;
        $display("Mismatch at time %0t: %s expected %0h, got %0h", $time, name,
                 expected, actual);
    endtask

    task automatic check_outputs(input stim_t s);
        expect_t e;
        e = predict_outputs(s, model_tag);
        if (result !== exp_result)
            report_mismatch("result_o", 128'(exp_result), 128'(result));
        if (write_enable !== exp_we)
            report_mismatch("write_enable_o", 128'(exp_we), 128'(write_enable));
        if (op_out !== exp_op)
            report_mismatch("op_o", 128'(exp_op), 128'(op_out));
        if (mem !== e.mem)
            report_mismatch("mem_o", 128'(e.mem), 128'(mem));
        if (csr !== e.csr)
            report_mismatch("csr_o", 128'(e.csr), 128'(csr));
        if (jump !== e.jump)
            report_mismatch("jump_o", 128'(e.jump), 128'(jump));
        if (jump_target !== e.target)
            report_mismatch("jump_target_o", 128'(e.target), 128'(jump_target));
        if (killed !== e.killed)
            report_mismatch("killed_o", 128'(e.killed), 128'(killed));
        if (trap !== e.trap)
            report_mismatch("trap_o", 128'(e.trap), 128'(trap));
        checks += 9;
        // Register values seen after the coming edge
        if (!s.stall) begin
            exp_result = e.result;
            exp_we = e.write_enable;
            exp_op = s.op;
        end
        flow_changed = e.jump || e.trap.raise_exception || e.trap.machine_return
                     || e.trap.interrupt_ack;
        if (flow_changed)
            model_tag = model_tag + TAG_W'(1);
    endtask

    task automatic run_test(input int test);
        int    errors_before;
        stim_t s;
        errors_before = errors;
        for (int i = 0; i < CYCLES_PER_TEST; i++) begin
            random_stimulus(test, s);
            @(posedge clk);
            drive_inputs(s);
            @(negedge clk);
            check_outputs(s);
        end
        $display("Test %0d %s: %0d cycles, %0d errors", test, test_name(test),
                 CYCLES_PER_TEST, errors - errors_before);
    endtask

    ////////////////////////////////////////////////////////////
    // Clock, watchdog and sequence
    ////////////////////////////////////////////////////////////

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("tests failed");
        $finish;
    end

    initial begin
        rng = 32'h7d176e01;
        model_tag = '0;
        exp_result = '0;
        exp_we = 1'b0;
        exp_op = NOP;
        flow_changed = 1'b0;
        stall_left = 0;
        errors = 0;
        checks = 0;
        reset_n <= 1'b0;
        drive_inputs('0);
        repeat (4) @(posedge clk);
        reset_n <= 1'b1;
        for (int t = 1; t <= NUM_TESTS; t++)
            run_test(t);
        $display("Summary: %0d tests, %0d checks, %0d errors", NUM_TESTS, checks, errors);
        if (errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+tb
hw/exec_pkg.sv
hw/alu.sv
hw/lsu_request.sv
hw/csr_access.sv
hw/flow_control.sv
hw/execute_stage.sv
tb/tb_execute.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_execute \
    --Mdir obj_dir -o tb_execute || { echo "Verilator build failed"; exit 1; }
out="$(./obj_dir/tb_execute)"
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "all tests passed" && exit 0 || exit 1
